// File: source/core_macros.svh
// ========================================
// word width, register count, buffer depth
// and the major opcodes kept by the core
// ========================================

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define CORE_XLEN      32
`define CORE_NREGS     32
`define CORE_RIDX_W    ($clog2(`CORE_NREGS))
`define CORE_BUF_DEPTH 4

// major opcodes, inst[6:0]
`define CORE_OPC_REG   7'b0110011
`define CORE_OPC_IMM   7'b0010011
`define CORE_OPC_LUI   7'b0110111

`endif

// File: source/core_pkg.sv
// ========================================
// core_pkg
// ALU operation enum and the payload
// structs passed between stage buffers
// ========================================

`include "core_macros.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui result is the operand b as is
        ALU_PASSB
    } alu_op_e;

    // decode to execute, 75 bits
    typedef struct packed {
        alu_op_e                 alu_op;
        logic [`CORE_RIDX_W-1:0] rd;
        logic [`CORE_XLEN-1:0]   opa;
        logic [`CORE_XLEN-1:0]   opb;
        logic                    wr;
        logic                    spare;
    } issue_t;

    // execute to writeback and retirement port, 38 bits
    typedef struct packed {
        logic [`CORE_RIDX_W-1:0] rd;
        logic                    wr;
        logic [`CORE_XLEN-1:0]   value;
    } result_t;

endpackage

// File: source/stage_buffer.sv
// ========================================
// stage_buffer
// first-word-fall-through FIFO between
// pipeline stages, payload type is a parameter
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module stage_buffer #(
    parameter type payload_t = logic [`CORE_XLEN-1:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t din,
    output payload_t dout,
    output logic     avail,
    output logic     full
);

    localparam int DEPTH = `CORE_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    assign avail = (count != '0);
    assign full  = (count == CNT_W'(DEPTH));
    // head entry shows without waiting for pop
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/regfile.sv
// ========================================
// regfile
// general-purpose registers, two async
// read ports and one write port
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CORE_RIDX_W-1:0] ra_idx,
    input  logic [`CORE_RIDX_W-1:0] rb_idx,
    input  logic                    we,
    input  logic [`CORE_RIDX_W-1:0] wr_idx,
    input  logic [`CORE_XLEN-1:0]   wr_data,
    output logic [`CORE_XLEN-1:0]   ra_data,
    output logic [`CORE_XLEN-1:0]   rb_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];

    // x0 is never written so it reads zero after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: source/decode_stage.sv
// ========================================
// decode_stage
// instruction decode, operand read and
// pending-register scoreboard
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module decode_stage
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CORE_XLEN-1:0]   inst,
    input  logic                    inst_avail,
    input  logic                    issue_full,
    input  logic [`CORE_XLEN-1:0]   ra_data,
    input  logic [`CORE_XLEN-1:0]   rb_data,
    input  logic                    wb_valid,
    input  logic [`CORE_RIDX_W-1:0] wb_rd,
    output logic                    inst_pop,
    output logic                    issue_push,
    output issue_t                  issue,
    output logic [`CORE_RIDX_W-1:0] ra_idx,
    output logic [`CORE_RIDX_W-1:0] rb_idx
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`CORE_RIDX_W-1:0] rd;
    logic                    is_reg;
    logic                    is_lui;
    logic                    alt;
    logic                    supported;
    logic                    wr;
    logic                    hazard;
    alu_op_e                 op;
    logic [`CORE_XLEN-1:0]   imm_i;
    logic [`CORE_XLEN-1:0]   imm_u;
    logic [`CORE_NREGS-1:0]  pending;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign ra_idx = inst[19:15];
    assign rb_idx = inst[24:20];
    assign funct7 = inst[31:25];
    assign is_reg = (opcode == `CORE_OPC_REG);
    assign is_lui = (opcode == `CORE_OPC_LUI);
    assign imm_i  = {{(`CORE_XLEN - 12){inst[31]}}, inst[31:20]};
    assign imm_u  = {inst[31:12], 12'b0};

    // sub only exists in the register form, sra in both
    assign alt = inst[30] & (is_reg | (funct3 == 3'b101));

    always_comb begin
        case (opcode)
            `CORE_OPC_REG: supported = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
            `CORE_OPC_IMM: begin
                if (funct3 == 3'b001) begin
                    supported = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    supported = 1'b1;
                end
            end
            `CORE_OPC_LUI: supported = 1'b1;
            default:       supported = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        if (is_lui) begin
            op = ALU_PASSB;
        end
    end

    assign wr = (rd != '0);

    // lui reads nothing, reg-imm reads rs1 only
    // an older write to rd still in flight also stalls
    assign hazard = (!is_lui && pending[ra_idx]) ||
                    (is_reg && pending[rb_idx]) ||
                    (wr && pending[rd]);

    assign issue_push = inst_avail && supported && !issue_full && !hazard;
    // unsupported opcodes are dropped at once
    assign inst_pop   = issue_push || (inst_avail && !supported);

    always_comb begin
        issue.alu_op = op;
        issue.rd     = rd;
        issue.opa    = is_lui ? '0 : ra_data;
        issue.opb    = is_reg ? rb_data : (is_lui ? imm_u : imm_i);
        issue.wr     = wr;
        issue.spare  = 1'b0;
    end

    // set comes last so it wins over a clear of the same bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_rd] <= 1'b0;
            end
            if (issue_push && wr) begin
                pending[rd] <= 1'b1;
            end
        end
    end

endmodule

// File: source/execute_stage.sv
// ========================================
// execute_stage
// combinational ALU, one issued op per
// cycle into the result buffer
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module execute_stage
    import core_pkg::*;
(
    input  issue_t  issue,
    input  logic    issue_avail,
    input  logic    result_full,
    output logic    issue_pop,
    output logic    result_push,
    output result_t result
);

    localparam int SH_W = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] y;
    logic [SH_W-1:0]       shamt;
    logic                  go;

    assign a     = issue.opa;
    assign b     = issue.opb;
    assign shamt = b[SH_W-1:0];

    assign go          = issue_avail && !result_full;
    assign issue_pop   = go;
    assign result_push = go;

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {{(`CORE_XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(`CORE_XLEN - 1){1'b0}}, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $unsigned($signed(a) >>> shamt);
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = b;
        endcase
    end

    assign result.rd    = issue.rd;
    assign result.wr    = issue.wr;
    assign result.value = y;

endmodule

// File: source/writeback_stage.sv
// ========================================
// writeback_stage
// register write, scoreboard clear and
// the retirement port
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module writeback_stage
    import core_pkg::*;
(
    input  result_t                 result,
    input  logic                    result_avail,
    output logic                    result_pop,
    output logic                    we,
    output logic [`CORE_RIDX_W-1:0] wr_idx,
    output logic [`CORE_XLEN-1:0]   wr_data,
    output logic                    wb_valid,
    output logic [`CORE_RIDX_W-1:0] wb_rd,
    output logic                    retire_valid,
    output result_t                 retire
);

    // never stalls, one result per cycle
    assign result_pop   = result_avail;
    assign retire_valid = result_avail;
    assign retire       = result;

    assign we      = result_avail && result.wr;
    assign wr_idx  = result.rd;
    assign wr_data = result.value;

    // same qualification as the write so decode clears only bits it set
    assign wb_valid = result_avail && result.wr;
    assign wb_rd    = result.rd;

endmodule

// File: source/cpu_core.sv
// ========================================
// cpu_core
// top level of the RV32I integer core
// stage buffers, stages and register file
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module cpu_core
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_we,
    input  logic [`CORE_XLEN-1:0] inst,
    output logic                  inst_full,
    output logic                  retire_valid,
    output result_t               retire
);

    logic [`CORE_XLEN-1:0]   fetch_dout;
    logic                    fetch_avail;
    logic                    fetch_pop;
    issue_t                  issue_din;
    issue_t                  issue_dout;
    logic                    issue_push;
    logic                    issue_pop;
    logic                    issue_avail;
    logic                    issue_full;
    result_t                 result_din;
    result_t                 result_dout;
    logic                    result_push;
    logic                    result_pop;
    logic                    result_avail;
    logic                    result_full;
    logic [`CORE_RIDX_W-1:0] ra_idx;
    logic [`CORE_RIDX_W-1:0] rb_idx;
    logic [`CORE_XLEN-1:0]   ra_data;
    logic [`CORE_XLEN-1:0]   rb_data;
    logic                    rf_we;
    logic [`CORE_RIDX_W-1:0] rf_wr_idx;
    logic [`CORE_XLEN-1:0]   rf_wr_data;
    logic                    wb_valid;
    logic [`CORE_RIDX_W-1:0] wb_rd;

    // instruction words from the outside agent
    stage_buffer #(.payload_t(logic [`CORE_XLEN-1:0])) fetch_buf (
        .clk(clk), .rst(rst), .push(inst_we), .pop(fetch_pop),
        .din(inst), .dout(fetch_dout), .avail(fetch_avail), .full(inst_full)
    );

    stage_buffer #(.payload_t(issue_t)) issue_buf (
        .clk(clk), .rst(rst), .push(issue_push), .pop(issue_pop),
        .din(issue_din), .dout(issue_dout), .avail(issue_avail), .full(issue_full)
    );

    stage_buffer #(.payload_t(result_t)) result_buf (
        .clk(clk), .rst(rst), .push(result_push), .pop(result_pop),
        .din(result_din), .dout(result_dout), .avail(result_avail), .full(result_full)
    );

    regfile gpr (
        .clk(clk), .rst(rst), .ra_idx(ra_idx), .rb_idx(rb_idx),
        .we(rf_we), .wr_idx(rf_wr_idx), .wr_data(rf_wr_data),
        .ra_data(ra_data), .rb_data(rb_data)
    );

    decode_stage decode (
        .clk(clk), .rst(rst), .inst(fetch_dout), .inst_avail(fetch_avail),
        .issue_full(issue_full), .ra_data(ra_data), .rb_data(rb_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .inst_pop(fetch_pop),
        .issue_push(issue_push), .issue(issue_din), .ra_idx(ra_idx), .rb_idx(rb_idx)
    );

    execute_stage execute (
        .issue(issue_dout), .issue_avail(issue_avail), .result_full(result_full),
        .issue_pop(issue_pop), .result_push(result_push), .result(result_din)
    );

    writeback_stage writeback (
        .result(result_dout), .result_avail(result_avail), .result_pop(result_pop),
        .we(rf_we), .wr_idx(rf_wr_idx), .wr_data(rf_wr_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd),
        .retire_valid(retire_valid), .retire(retire)
    );

endmodule

// File: bench/cpu_core_chk.sv
// ========================================
// strobe assertions for every stage buffer
// and the bind that attaches them
// ========================================

`timescale 1ns/1ps

module cpu_core_chk (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic avail,
    input logic full
);

    // failed assertion count
    int errors = 0;

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else begin
            $error("push while the buffer is full");
            errors++;
        end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> avail)
        else begin
            $error("pop while the buffer is empty");
            errors++;
        end

    // first edge after reset release
    empty_after_reset: assert property (@(posedge clk) $fell(rst) |-> (!avail && !full))
        else begin
            $error("buffer not empty right after reset");
            errors++;
        end

endmodule

bind stage_buffer cpu_core_chk chk (
    .clk(clk), .rst(rst), .push(push), .pop(pop), .avail(avail), .full(full)
);

// File: bench/cpu_core_tb.sv
// ========================================
// testbench for the RV32I core
// instruction table, random push gaps,
// retirement monitor and summary
// ========================================

`timescale 1ns/1ps
`include "core_macros.svh"

module cpu_core_tb
    import core_pkg::*;
();

    localparam int MAX_TESTS = 40;

    logic        clk;
    logic        rst;
    logic        inst_we;
    logic [31:0] inst;
    logic        inst_full;
    logic        retire_valid;
    result_t     retire;

    string       names [MAX_TESTS];
    logic [31:0] words [MAX_TESTS];
    result_t     exp_res [MAX_TESTS];
    bit          retires [MAX_TESTS];
    int          num_tests;
    int          num_retiring;
    int          burst_start;
    int          next_idx;
    int          seen;
    int          pass_count;
    int          fail_count;
    int          cycles;
    int          limit;
    int          gap;
    int          assert_errors;

    cpu_core DUT (
        .clk(clk), .rst(rst), .inst_we(inst_we), .inst(inst),
        .inst_full(inst_full), .retire_valid(retire_valid), .retire(retire)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `CORE_OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `CORE_OPC_LUI};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] word,
                             input logic [4:0] rd, input logic [31:0] value, input bit ret);
        names[num_tests]         = name;
        words[num_tests]         = word;
        exp_res[num_tests].rd    = rd;
        exp_res[num_tests].wr    = (rd != 5'd0);
        exp_res[num_tests].value = value;
        retires[num_tests]       = ret;
        num_retiring += ret;
        num_tests++;
    endtask

    // instruction words and the results they should retire
    task automatic build_table();
        add_entry("add_zero", enc_r(7'h00, 0, 0, 3'b000, 5), 5, 32'h0, 1);
        add_entry("addi_pos", enc_i(12'd100, 0, 3'b000, 1, `CORE_OPC_IMM), 1, 32'h64, 1);
        add_entry("addi_neg", enc_i(12'hFFB, 0, 3'b000, 2, `CORE_OPC_IMM), 2, 32'hFFFFFFFB, 1);
        add_entry("slti", enc_i(12'd1, 2, 3'b010, 3, `CORE_OPC_IMM), 3, 32'h1, 1);
        add_entry("sltiu", enc_i(12'd1, 2, 3'b011, 4, `CORE_OPC_IMM), 4, 32'h0, 1);
        add_entry("xori", enc_i(12'h00F, 1, 3'b100, 6, `CORE_OPC_IMM), 6, 32'h6B, 1);
        add_entry("ori", enc_i(12'hF00, 1, 3'b110, 7, `CORE_OPC_IMM), 7, 32'hFFFFFF64, 1);
        add_entry("andi", enc_i(12'h0FF, 2, 3'b111, 8, `CORE_OPC_IMM), 8, 32'hFB, 1);
        add_entry("slli", enc_i(12'h004, 1, 3'b001, 9, `CORE_OPC_IMM), 9, 32'h640, 1);
        add_entry("srli", enc_i(12'd28, 2, 3'b101, 10, `CORE_OPC_IMM), 10, 32'hF, 1);
        add_entry("srai", enc_i(12'h401, 2, 3'b101, 11, `CORE_OPC_IMM), 11, 32'hFFFFFFFD, 1);
        add_entry("lui", enc_u(20'hABCDE, 12), 12, 32'hABCDE000, 1);
        // load opcode is not kept
        add_entry("bad_opcode", enc_i(12'h0, 1, 3'b010, 13, 7'b0000011), 13, 32'h0, 0);
        add_entry("add", enc_r(7'h00, 2, 1, 3'b000, 13), 13, 32'h5F, 1);
        add_entry("sub", enc_r(7'h20, 2, 1, 3'b000, 14), 14, 32'h69, 1);
        add_entry("sll", enc_r(7'h00, 3, 2, 3'b001, 15), 15, 32'hFFFFFFF6, 1);
        add_entry("slt", enc_r(7'h00, 1, 2, 3'b010, 16), 16, 32'h1, 1);
        add_entry("sltu", enc_r(7'h00, 1, 2, 3'b011, 17), 17, 32'h0, 1);
        add_entry("xor", enc_r(7'h00, 2, 12, 3'b100, 18), 18, 32'h54321FFB, 1);
        add_entry("srl", enc_r(7'h00, 3, 12, 3'b101, 19), 19, 32'h55E6F000, 1);
        add_entry("sra", enc_r(7'h20, 3, 12, 3'b101, 20), 20, 32'hD5E6F000, 1);
        add_entry("or", enc_r(7'h00, 8, 1, 3'b110, 21), 21, 32'hFF, 1);
        add_entry("and", enc_r(7'h00, 6, 10, 3'b111, 22), 22, 32'hB, 1);
        // retires with wr low and leaves x0 at zero
        add_entry("x0_write", enc_i(12'd7, 1, 3'b000, 0, `CORE_OPC_IMM), 0, 32'h6B, 1);
        add_entry("x0_read", enc_r(7'h00, 1, 0, 3'b000, 23), 23, 32'h64, 1);
        add_entry("bad_funct", enc_r(7'h01, 2, 1, 3'b000, 13), 13, 32'h0, 0);
        burst_start = num_tests;
        add_entry("burst_addi1", enc_i(12'd1, 0, 3'b000, 24, `CORE_OPC_IMM), 24, 32'h1, 1);
        add_entry("burst_addi2", enc_i(12'd2, 0, 3'b000, 25, `CORE_OPC_IMM), 25, 32'h2, 1);
        add_entry("burst_addi3", enc_i(12'd3, 0, 3'b000, 26, `CORE_OPC_IMM), 26, 32'h3, 1);
        add_entry("burst_lui", enc_u(20'h12345, 27), 27, 32'h12345000, 1);
        add_entry("burst_ori", enc_i(12'h7FF, 0, 3'b110, 28, `CORE_OPC_IMM), 28, 32'h7FF, 1);
        add_entry("burst_addi_min", enc_i(12'h800, 0, 3'b000, 29, `CORE_OPC_IMM), 29,
                  32'hFFFFF800, 1);
        add_entry("final_or", enc_r(7'h00, 28, 27, 3'b110, 30), 30, 32'h123457FF, 1);
    endtask

    task automatic compare(input string name, input logic [37:0] exp, input logic [37:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            fail_count++;
        end else begin
            $display("ok %s %h", name, act);
            pass_count++;
        end
    endtask

    // starts and ends 1 ns after a clock edge
    task automatic push_word(input logic [31:0] word);
        while (inst_full) begin
            @(posedge clk);
            #1;
        end
        inst_we = 1'b1;
        inst    = word;
        @(posedge clk);
        #1;
        inst_we = 1'b0;
    endtask

    // dropped entries are skipped before each retirement is checked
    always @(posedge clk) begin
        if (!rst && retire_valid) begin
            while (next_idx < num_tests && !retires[next_idx]) begin
                $display("ok %s dropped without retiring", names[next_idx]);
                pass_count++;
                next_idx++;
            end
            if (next_idx < num_tests) begin
                compare(names[next_idx], exp_res[next_idx], retire);
                next_idx++;
                seen++;
            end else begin
                $display("unexpected retirement of x%0d value %h", retire.rd, retire.value);
                fail_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, only %0d of %0d retirements seen",
                     cycles, seen, num_retiring);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(15));
        rst          = 1'b1;
        inst_we      = 1'b0;
        inst         = '0;
        num_tests    = 0;
        num_retiring = 0;
        next_idx     = 0;
        seen         = 0;
        pass_count   = 0;
        fail_count   = 0;
        cycles       = 0;
        build_table();
        limit = num_tests * 20 + 100;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        compare("reset_inst_full", 38'd0, inst_full);
        compare("reset_retire_valid", 38'd0, retire_valid);
        for (int i = 0; i < num_tests; i++) begin
            // shorter gaps in the burst
            gap = (i >= burst_start) ? ($urandom % 2) : ($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            push_word(words[i]);
        end
        while (seen < num_retiring) begin
            @(posedge clk);
        end
        // room for a stray extra retirement to show up
        repeat (4) @(posedge clk);
        assert_errors = DUT.fetch_buf.chk.errors + DUT.issue_buf.chk.errors +
                        DUT.result_buf.chk.errors;
        if (assert_errors != 0) begin
            $display("stage buffer assertions failed %0d times", assert_errors);
            fail_count += assert_errors;
        end
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+source
source/core_pkg.sv
source/stage_buffer.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_core.sv
bench/cpu_core_chk.sv
bench/cpu_core_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/stage_buffer.sv
      - source/regfile.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/writeback_stage.sv
      - source/cpu_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/cpu_core_chk.sv
      - bench/cpu_core_tb.sv
